// ==== vgafb_stimulus.txt ====
# op addr data in hex: w writes data, r reads and expects data
# v waits for addr rising vsync edges, n idles for addr cycles
r 0000 00000001
r 0001 00000280
r 0002 00000290
r 0003 000002f0
r 0004 0000031f
r 0005 000001e0
r 0006 000001eb
r 0007 000001ed
r 0008 0000020b
r 0009 00000000
r 000a 00000000
r 000b 00004b00
r 000c 00000000
w 0001 ffff0010
r 0001 00000010
w 0002 00000014
w 0003 0000001a
w 0004 0000001f
w 0005 00000004
w 0006 00000006
w 0007 00000008
w 0008 00000009
w 000b 00000004
w 000c ffffffff
r 000c 00000003
w 000a 12345678
r 000a 00000000
r 0401 00000000
r 000d 00000000
w 0009 fc001000
r 0009 00001000
w 0000 00000000
v 2 0
r 000a 00001000
w 0009 00002000
r 000a 00001000
v 1 0
r 000a 00002000
v 1 0
w 0000 00000001
n 20 0
r 0000 00000001

// ==== list.f ====
vgafb_pkg.sv
vgafb_cfg_if.sv
vgafb_ctlif.sv
vgafb_timing.sv
vgafb_fetch.sv
vgafb_fifo.sv
vgafb_top.sv
vgafb_clkgen.sv
vgafb_checker.sv
vgafb_assertions.sv
vgafb_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the vga framebuffer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module vgafb_tb -f list.f -o vgafb_sim

output=$(./obj_dir/vgafb_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

// ==== vgafb_tb.sv ====
//////////////////////////////
// vga framebuffer testbench
//////////////////////////////
`default_nettype none

module vgafb_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import vgafb_pkg::*;

	// 32 by 10 test frame, about five frames run plus reads.
	localparam int frame_cycles = 32 * 10;
	localparam int max_cycles = 8 * frame_cycles + 1000;
	// frames two to four carry 64 pixels each.
	localparam int min_pixels = 3 * 64;

	logic sys_clk;
	logic sys_rst;
	logic [csr_aw-1:0] csr_a;
	logic csr_we;
	logic [csr_dw-1:0] csr_di;
	logic [csr_dw-1:0] csr_do;
	logic [fml_depth-1:0] mem_adr;
	logic mem_stb;
	logic mem_ack;
	logic [mem_dw-1:0] mem_di;
	logic hsync;
	logic vsync;
	logic de;
	logic [pix_w-1:0] rgb;
	logic [clk_sel_width-1:0] vga_clk_sel;
	logic rd_check;
	logic [csr_dw-1:0] rd_expect;
	int csr_errors;
	int pixel_errors;
	int timing_errors;
	int pixels_checked;
	int other_errors;
	int cycles;
	int seed;

	vgafb_clkgen #(.period(100), .rst_cycles(10)) u_clkgen (
		.sys_clk(sys_clk), .sys_rst(sys_rst)
	);

	vgafb_top dut (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.mem_adr(mem_adr), .mem_stb(mem_stb), .mem_ack(mem_ack), .mem_di(mem_di),
		.hsync(hsync), .vsync(vsync), .de(de), .rgb(rgb), .vga_clk_sel(vga_clk_sel)
	);

	vgafb_checker u_checker (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.rd_check(rd_check), .rd_expect(rd_expect), .mem_stb(mem_stb),
		.hsync(hsync), .vsync(vsync), .de(de), .rgb(rgb), .vga_clk_sel(vga_clk_sel),
		.csr_errors(csr_errors), .pixel_errors(pixel_errors),
		.timing_errors(timing_errors), .pixels_checked(pixels_checked)
	);

	//////////////////////////////
	// memory model
	//////////////////////////////

	// each lane is the beat address low bits plus the lane number.
	function automatic logic [mem_dw-1:0] beat_word(input logic [fml_depth-1:0] adr);
		logic [mem_dw-1:0] w;
		for (int l = 0; l < 4; l++)
			w[16*l +: 16] = adr[15:0] + 16'(l);
		return w;
	endfunction

	initial begin : memory_model
		int wait_cnt;
		int beats_left;
		logic [fml_depth-1:0] beat_adr;
		seed = 56;
		mem_ack = 1'b0;
		mem_di = '0;
		beats_left = 0;
		beat_adr = '0;
		wait_cnt = {$random(seed)} % 4;
		forever begin
			@(negedge sys_clk);
			mem_ack = 1'b0;
			if (beats_left > 0) begin
				mem_di = beat_word(beat_adr);
				beat_adr = beat_adr + fml_depth'(8);
				beats_left--;
			end else if (mem_stb) begin
				if (wait_cnt == 0) begin
					// ack cycle carries beat 0.
					mem_ack = 1'b1;
					mem_di = beat_word(mem_adr);
					beat_adr = mem_adr + fml_depth'(8);
					beats_left = 3;
					wait_cnt = {$random(seed)} % 4;
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	//////////////////////////////
	// stimulus reader
	//////////////////////////////

	task automatic bus_idle();
		csr_we = 1'b0;
		rd_check = 1'b0;
	endtask

	// counts rising vsync edges seen on falling clock edges.
	task automatic wait_vsync_rises(input int count);
		int seen;
		logic prev;
		seen = 0;
		prev = vsync;
		while (seen < count) begin
			@(negedge sys_clk);
			if (vsync && !prev)
				seen++;
			prev = vsync;
		end
	endtask

	task automatic run_stimulus(input int fd);
		string line;
		byte op;
		logic [31:0] a;
		logic [31:0] d;
		int n;
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin
				n = $sscanf(line, "%c %h %h", op, a, d);
				@(negedge sys_clk);
				bus_idle();
				csr_a = a[csr_aw-1:0];
				case (op)
					"w": begin
						csr_di = d;
						csr_we = 1'b1;
					end
					"r": begin
						rd_expect = d;
						rd_check = 1'b1;
					end
					"v": wait_vsync_rises(int'(a));
					"n": repeat (int'(a)) @(negedge sys_clk);
					default: begin
						other_errors++;
						$display("unknown stimulus command: %s", line);
					end
				endcase
			end
		end
		@(negedge sys_clk);
		bus_idle();
	endtask

	initial begin : stimulus
		int fd;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		rd_check = 1'b0;
		rd_expect = '0;
		other_errors = 0;
		fd = $fopen("vgafb_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			@(negedge sys_clk);
			while (sys_rst)
				@(negedge sys_clk);
			run_stimulus(fd);
			$fclose(fd);
			repeat (5) @(negedge sys_clk);
			if (pixels_checked < min_pixels) begin
				other_errors++;
				$display("too few pixels were compared: %0d", pixels_checked);
			end
			$display("errors: csr %0d pixel %0d timing %0d other %0d", csr_errors,
				pixel_errors, timing_errors, other_errors);
			if (csr_errors + pixel_errors + timing_errors + other_errors == 0) begin
				$display("TEST RESULT: PASS");
			end else begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

	// run limit.
	initial begin : watchdog
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("run stopped after %0d cycles before the stimulus ended", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end
endmodule

`default_nettype wire

// ==== vgafb_assertions.sv ====
//////////////////////////////
// fetch port assertions
//////////////////////////////
`default_nettype none

module vgafb_assertions (
	input wire sys_clk,
	input wire sys_rst,
	input wire vga_rst,
	input wire mem_stb,
	input wire mem_ack,
	input wire push,
	input wire [vgafb_pkg::fml_depth-1:0] mem_adr
);
	timeunit 1ns;
	timeprecision 1ps;

	// address held while the request waits.
	adr_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_stb && !mem_ack |=> $stable(mem_adr))
		else $error("memory address changed while the strobe waited for ack");

	// display reset abandons any burst in flight.
	stb_in_reset: assert property (@(posedge sys_clk) disable iff (sys_rst)
		vga_rst |=> !mem_stb && !push)
		else $error("memory strobe or fifo push after the display was put in reset");

	// 32 byte bursts.
	adr_aligned: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_stb |-> mem_adr[4:0] == 5'd0)
		else $error("burst address not aligned to the burst size");
endmodule

bind vgafb_fetch vgafb_assertions u_assertions (
	.sys_clk(sys_clk), .sys_rst(sys_rst), .vga_rst(cfg.vga_rst),
	.mem_stb(mem_stb), .mem_ack(mem_ack), .push(push), .mem_adr(mem_adr)
);

`default_nettype wire

// ==== vgafb_checker.sv ====
//////////////////////////////
// output monitor
//////////////////////////////
`default_nettype none

module vgafb_checker (
	input wire sys_clk,
	input wire sys_rst,
	input wire [vgafb_pkg::csr_aw-1:0] csr_a,
	input wire csr_we,
	input wire [vgafb_pkg::csr_dw-1:0] csr_di,
	input wire [vgafb_pkg::csr_dw-1:0] csr_do,
	input wire rd_check,
	input wire [vgafb_pkg::csr_dw-1:0] rd_expect,
	input wire mem_stb,
	input wire hsync,
	input wire vsync,
	input wire de,
	input wire [vgafb_pkg::pix_w-1:0] rgb,
	input wire [vgafb_pkg::clk_sel_width-1:0] vga_clk_sel,
	output int csr_errors,
	output int pixel_errors,
	output int timing_errors,
	output int pixels_checked
);
	timeunit 1ns;
	timeprecision 1ps;
	import vgafb_pkg::*;

	logic rd_pend;
	logic [csr_dw-1:0] rd_exp_q;
	// shadow copies of what the host wrote.
	logic [fml_depth-1:0] base_s;
	logic [fml_depth-1:0] frame_base;
	logic [timing_width-1:0] hres_s;
	logic [timing_width-1:0] hs_start_s;
	logic [timing_width-1:0] hs_end_s;
	logic [timing_width-1:0] hscan_s;
	logic [clk_sel_width-1:0] clk_sel_s;
	logic rst_s;
	int rst_age;
	logic valid;
	int pix_idx;
	logic hsync_q;
	logic vsync_q;
	logic seen_fall;
	int line_len;
	int hs_len;
	int de_len;
	logic [pix_w-1:0] exp_pix;

	// memory holds address low bits plus lane in each 16 bit lane.
	function automatic logic [pix_w-1:0] predict_pixel(input logic [fml_depth-1:0] base,
			input int idx);
		logic [fml_depth-1:0] addr;
		addr = base + fml_depth'(8 * (idx / 4));
		return addr[15:0] + 16'(idx % 4);
	endfunction

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_errors = 0;
			pixel_errors = 0;
			timing_errors = 0;
			pixels_checked = 0;
			rd_pend = 1'b0;
			rd_exp_q = '0;
			base_s = '0;
			frame_base = '0;
			hres_s = rst_hres;
			hs_start_s = rst_hsync_start;
			hs_end_s = rst_hsync_end;
			hscan_s = rst_hscan;
			clk_sel_s = rst_clk_sel;
			rst_s = 1'b1;
			rst_age = 2;
			valid = 1'b0;
			pix_idx = 0;
			hsync_q = 1'b0;
			vsync_q = 1'b0;
			seen_fall = 1'b0;
		end else begin
			//////////////////////////////
			// csr read data
			//////////////////////////////
			if (rd_pend && csr_do !== rd_exp_q) begin
				csr_errors++;
				$display("error %0t csr_do expected %h got %h", $time, rd_exp_q, csr_do);
			end
			rd_pend = rd_check;
			rd_exp_q = rd_expect;

			// clock select pin follows its register.
			if (vga_clk_sel !== clk_sel_s) begin
				csr_errors++;
				$display("error %0t vga_clk_sel expected %h got %h", $time, clk_sel_s,
					vga_clk_sel);
			end

			if (rst_s) begin
				// outputs lag the register by a cycle.
				if (rst_age >= 1 && (hsync || vsync || de)) begin
					timing_errors++;
					$display("sync or de still active at %0t with the display in reset", $time);
				end
				if (rst_age >= 1 && mem_stb) begin
					timing_errors++;
					$display("memory strobe at %0t with the display in reset", $time);
				end
				rst_age++;
			end else begin
				// vsync rise comes after the fetch of the next frame started.
				if (vsync && !vsync_q) begin
					valid = 1'b1;
					frame_base = base_s;
					pix_idx = 0;
				end
				if (de) begin
					exp_pix = valid ? predict_pixel(frame_base, pix_idx) : '0;
					if (rgb !== exp_pix) begin
						pixel_errors++;
						$display("error %0t rgb expected %h got %h", $time, exp_pix, rgb);
					end
					if (valid)
						pixels_checked++;
					pix_idx++;
					de_len++;
				end
				if (hsync)
					hs_len++;
				line_len++;
				// one line spans two hsync falls.
				if (!hsync && hsync_q) begin
					if (seen_fall) begin
						if (line_len != int'(hscan_s) + 1) begin
							timing_errors++;
							$display("error %0t line_len expected %0d got %0d", $time,
								int'(hscan_s) + 1, line_len);
						end
						if (hs_len != int'(hs_end_s) - int'(hs_start_s)) begin
							timing_errors++;
							$display("error %0t hsync_len expected %0d got %0d", $time,
								int'(hs_end_s) - int'(hs_start_s), hs_len);
						end
						if (de_len != 0 && de_len != int'(hres_s)) begin
							timing_errors++;
							$display("error %0t de_len expected %0d got %0d", $time,
								int'(hres_s), de_len);
						end
					end
					seen_fall = 1'b1;
					line_len = 0;
					hs_len = 0;
					de_len = 0;
				end
			end
			hsync_q = hsync;
			vsync_q = vsync;

			//////////////////////////////
			// track host writes
			//////////////////////////////
			if (csr_we && csr_a[13:10] == csr_addr) begin
				case (csr_a[3:0])
					reg_vga_rst: begin
						rst_s = csr_di[0];
						rst_age = 0;
						valid = 1'b0;
						pix_idx = 0;
						seen_fall = 1'b0;
					end
					reg_hres: hres_s = csr_di[timing_width-1:0];
					reg_hsync_start: hs_start_s = csr_di[timing_width-1:0];
					reg_hsync_end: hs_end_s = csr_di[timing_width-1:0];
					reg_hscan: hscan_s = csr_di[timing_width-1:0];
					reg_baseaddress: base_s = csr_di[fml_depth-1:0];
					reg_vga_clk_sel: clk_sel_s = csr_di[clk_sel_width-1:0];
					default: ;
				endcase
			end
		end
	end
endmodule

`default_nettype wire

// ==== vgafb_clkgen.sv ====
//////////////////////////////
// clock and reset source
//////////////////////////////
`default_nettype none

module vgafb_clkgen #(
	parameter int period = 100,
	parameter int rst_cycles = 10
) (
	output logic sys_clk,
	output logic sys_rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		sys_clk = 1'b0;
		forever #(period / 2) sys_clk = ~sys_clk;
	end

	// released on a falling edge.
	initial begin
		sys_rst = 1'b1;
		repeat (rst_cycles) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
	end
endmodule

`default_nettype wire

// ==== vgafb_top.sv ====
//////////////////////////////
// vga framebuffer top
//////////////////////////////
`default_nettype none

module vgafb_top (
	input wire sys_clk,
	input wire sys_rst,

	// csr bus.
	input wire [vgafb_pkg::csr_aw-1:0] csr_a,
	input wire csr_we,
	input wire [vgafb_pkg::csr_dw-1:0] csr_di,
	output logic [vgafb_pkg::csr_dw-1:0] csr_do,

	// memory read port.
	output logic [vgafb_pkg::fml_depth-1:0] mem_adr,
	output logic mem_stb,
	input wire mem_ack,
	input wire [vgafb_pkg::mem_dw-1:0] mem_di,

	// video out.
	output logic hsync,
	output logic vsync,
	output logic de,
	output logic [vgafb_pkg::pix_w-1:0] rgb,
	output logic [vgafb_pkg::clk_sel_width-1:0] vga_clk_sel
);
	import vgafb_pkg::*;

	logic frame_start;
	logic room;
	logic push;
	logic [mem_dw-1:0] wdata;
	logic pix_pop;
	logic [pix_w-1:0] pix_data;

	vgafb_cfg_if cfg ();

	vgafb_ctlif u_ctlif (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.cfg(cfg.ctl),
		.vga_clk_sel(vga_clk_sel)
	);

	vgafb_timing u_timing (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.cfg(cfg.timing),
		.pix_data(pix_data), .pix_pop(pix_pop), .frame_start(frame_start),
		.hsync(hsync), .vsync(vsync), .de(de), .rgb(rgb)
	);

	vgafb_fetch u_fetch (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.cfg(cfg.fetch),
		.frame_start(frame_start), .room(room), .push(push), .wdata(wdata),
		.mem_adr(mem_adr), .mem_stb(mem_stb), .mem_ack(mem_ack), .mem_di(mem_di)
	);

	// display reset also empties the fifo.
	vgafb_fifo u_fifo (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .flush(cfg.vga_rst),
		.push(push), .wdata(wdata), .room(room),
		.pix_pop(pix_pop), .pix_data(pix_data)
	);
endmodule

`default_nettype wire

// ==== vgafb_fifo.sv ====
//////////////////////////////
// pixel fifo
//////////////////////////////
`default_nettype none

module vgafb_fifo (
	input wire sys_clk,
	input wire sys_rst,
	input wire flush,

	input wire push,
	input wire [vgafb_pkg::mem_dw-1:0] wdata,
	output logic room,

	input wire pix_pop,
	output logic [vgafb_pkg::pix_w-1:0] pix_data
);
	import vgafb_pkg::*;

	logic [mem_dw-1:0] mem [fifo_depth_words];
	logic [fifo_aw-1:0] wr_ptr;
	logic [fifo_aw-1:0] rd_ptr;
	logic [fifo_aw:0] level;
	logic [lane_w-1:0] lane;
	logic [mem_dw-1:0] head;
	logic push_ok;
	logic pop_ok;
	logic retire;

	// msb of level set means full.
	assign push_ok = push && !level[fifo_aw];
	assign pop_ok = pix_pop && (level != '0);
	// head word leaves after its last lane.
	assign retire = pop_ok && (lane == last_lane);

	// space for one more burst.
	assign room = level <= (fifo_depth_words - burst_len);

	// lane 0 in the low bits.
	assign head = mem[rd_ptr];
	assign pix_data = (level != '0) ? head[lane*pix_w +: pix_w] : '0;

	always_ff @(posedge sys_clk) begin
		if (push_ok)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			lane <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (retire)
				rd_ptr <= rd_ptr + 1'b1;
			if (pop_ok)
				lane <= lane + 1'b1;
			// level counts whole words.
			case ({push_ok, retire})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: ;
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== vgafb_fetch.sv ====
//////////////////////////////
// framebuffer burst dma
//////////////////////////////
`default_nettype none

module vgafb_fetch (
	input wire sys_clk,
	input wire sys_rst,

	vgafb_cfg_if.fetch cfg,

	input wire frame_start,
	input wire room,
	output logic push,
	output logic [vgafb_pkg::mem_dw-1:0] wdata,

	output logic [vgafb_pkg::fml_depth-1:0] mem_adr,
	output logic mem_stb,
	input wire mem_ack,
	input wire [vgafb_pkg::mem_dw-1:0] mem_di
);
	import vgafb_pkg::*;

	logic [1:0] state;
	logic [nbursts_width-1:0] bursts_left;
	logic [beat_w-1:0] beat;
	logic start;
	logic ack_ok;

	// new frame only from idle.
	assign cfg.baseaddress_ack = (state == fetch_idle) && frame_start && !cfg.vga_rst;
	assign start = cfg.baseaddress_ack && (cfg.nbursts != '0);

	// request only with space for a full burst.
	assign mem_stb = (state == fetch_req) && room && !cfg.vga_rst;
	assign ack_ok = mem_stb && mem_ack;

	// ack cycle carries beat 0.
	assign push = ack_ok || (state == fetch_beats);
	assign wdata = mem_di;

	//////////////////////////////
	// fsm
	//////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst || cfg.vga_rst) begin
			state <= fetch_idle;
			bursts_left <= '0;
			beat <= '0;
		end else begin
			// beat index wraps after the last beat.
			if (push)
				beat <= beat + 1'b1;
			case (state)
				fetch_idle: begin
					if (start) begin
						state <= fetch_req;
						bursts_left <= cfg.nbursts;
						mem_adr <= cfg.baseaddress;
					end
				end
				fetch_req: begin
					if (ack_ok) begin
						state <= fetch_beats;
						bursts_left <= bursts_left - 1'b1;
					end
				end
				fetch_beats: begin
					if (beat == last_beat) begin
						// next burst address.
						mem_adr <= mem_adr + fml_depth'(burst_bytes);
						if (bursts_left == '0)
							state <= fetch_idle;
						else
							state <= fetch_req;
					end
				end
				default: state <= fetch_idle;
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== vgafb_timing.sv ====
//////////////////////////////
// vga sync generator
//////////////////////////////
`default_nettype none

module vgafb_timing (
	input wire sys_clk,
	input wire sys_rst,

	vgafb_cfg_if.timing cfg,

	input wire [vgafb_pkg::pix_w-1:0] pix_data,
	output logic pix_pop,
	output logic frame_start,

	output logic hsync,
	output logic vsync,
	output logic de,
	output logic [vgafb_pkg::pix_w-1:0] rgb
);
	import vgafb_pkg::*;

	logic [timing_width-1:0] hcount;
	logic [timing_width-1:0] vcount;
	logic line_end;
	logic frame_end;
	logic active;
	logic hsync_c;
	logic vsync_c;

	//////////////////////////////
	// counters
	//////////////////////////////

	assign line_end = hcount == cfg.hscan;
	assign frame_end = line_end && (vcount == cfg.vscan);

	// held at 0,0 while the display is in reset.
	always_ff @(posedge sys_clk) begin
		if (sys_rst || cfg.vga_rst) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			if (frame_end)
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	//////////////////////////////
	// decode
	//////////////////////////////

	assign active = (hcount < cfg.hres) && (vcount < cfg.vres);
	assign hsync_c = (hcount >= cfg.hsync_start) && (hcount < cfg.hsync_end);
	assign vsync_c = (vcount >= cfg.vsync_start) && (vcount < cfg.vsync_end);

	// one pixel per active cycle.
	assign pix_pop = active && !cfg.vga_rst;

	// pulse at the end of the last active line.
	// fetch fills the fifo during vertical blanking, ahead of line 0.
	assign frame_start = !cfg.vga_rst && line_end && (vcount == cfg.vres - 1'b1);

	// registered outputs, one cycle behind the counters.
	always_ff @(posedge sys_clk) begin
		if (sys_rst || cfg.vga_rst) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de <= 1'b0;
			rgb <= '0;
		end else begin
			hsync <= hsync_c;
			vsync <= vsync_c;
			de <= active;
			// black outside the active area.
			rgb <= active ? pix_data : '0;
		end
	end
endmodule

`default_nettype wire

// ==== vgafb_ctlif.sv ====
//////////////////////////////
// vga csr register file
//////////////////////////////
`default_nettype none

module vgafb_ctlif (
	input wire sys_clk,
	input wire sys_rst,

	input wire [vgafb_pkg::csr_aw-1:0] csr_a,
	input wire csr_we,
	input wire [vgafb_pkg::csr_dw-1:0] csr_di,
	output logic [vgafb_pkg::csr_dw-1:0] csr_do,

	vgafb_cfg_if.ctl cfg,

	output logic [vgafb_pkg::clk_sel_width-1:0] vga_clk_sel
);
	import vgafb_pkg::*;

	// base the fetch engine is actually using.
	logic [fml_depth-1:0] baseaddress_act;
	logic csr_selected;

	// bank select on the upper address bits.
	assign csr_selected = csr_a[13:10] == csr_addr;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			baseaddress_act <= '0;
		else if (cfg.baseaddress_ack)
			baseaddress_act <= cfg.baseaddress;
	end

	//////////////////////////////
	// writes
	//////////////////////////////

	// takes effect on the edge with csr_we high.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg.vga_rst <= rst_vga_rst;
			cfg.hres <= rst_hres;
			cfg.hsync_start <= rst_hsync_start;
			cfg.hsync_end <= rst_hsync_end;
			cfg.hscan <= rst_hscan;
			cfg.vres <= rst_vres;
			cfg.vsync_start <= rst_vsync_start;
			cfg.vsync_end <= rst_vsync_end;
			cfg.vscan <= rst_vscan;
			cfg.baseaddress <= '0;
			cfg.nbursts <= rst_nbursts;
			vga_clk_sel <= rst_clk_sel;
		end else if (csr_selected && csr_we) begin
			case (csr_a[3:0])
				reg_vga_rst: cfg.vga_rst <= csr_di[0];
				reg_hres: cfg.hres <= csr_di[timing_width-1:0];
				reg_hsync_start: cfg.hsync_start <= csr_di[timing_width-1:0];
				reg_hsync_end: cfg.hsync_end <= csr_di[timing_width-1:0];
				reg_hscan: cfg.hscan <= csr_di[timing_width-1:0];
				reg_vres: cfg.vres <= csr_di[timing_width-1:0];
				reg_vsync_start: cfg.vsync_start <= csr_di[timing_width-1:0];
				reg_vsync_end: cfg.vsync_end <= csr_di[timing_width-1:0];
				reg_vscan: cfg.vscan <= csr_di[timing_width-1:0];
				reg_baseaddress: cfg.baseaddress <= csr_di[fml_depth-1:0];
				// active base is read only.
				reg_nbursts: cfg.nbursts <= csr_di[nbursts_width-1:0];
				reg_vga_clk_sel: vga_clk_sel <= csr_di[clk_sel_width-1:0];
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// reads
	//////////////////////////////

	// one cycle of latency, zero outside the map.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else if (!csr_selected) begin
			csr_do <= '0;
		end else begin
			case (csr_a[3:0])
				reg_vga_rst: csr_do <= csr_dw'(cfg.vga_rst);
				reg_hres: csr_do <= csr_dw'(cfg.hres);
				reg_hsync_start: csr_do <= csr_dw'(cfg.hsync_start);
				reg_hsync_end: csr_do <= csr_dw'(cfg.hsync_end);
				reg_hscan: csr_do <= csr_dw'(cfg.hscan);
				reg_vres: csr_do <= csr_dw'(cfg.vres);
				reg_vsync_start: csr_do <= csr_dw'(cfg.vsync_start);
				reg_vsync_end: csr_do <= csr_dw'(cfg.vsync_end);
				reg_vscan: csr_do <= csr_dw'(cfg.vscan);
				reg_baseaddress: csr_do <= csr_dw'(cfg.baseaddress);
				reg_baseaddress_act: csr_do <= csr_dw'(baseaddress_act);
				reg_nbursts: csr_do <= csr_dw'(cfg.nbursts);
				reg_vga_clk_sel: csr_do <= csr_dw'(vga_clk_sel);
				default: csr_do <= '0;
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== vgafb_cfg_if.sv ====
//////////////////////////////
// vga control registers
//////////////////////////////
`default_nettype none

interface vgafb_cfg_if;
	import vgafb_pkg::*;

	logic vga_rst;
	// horizontal timing.
	logic [timing_width-1:0] hres;
	logic [timing_width-1:0] hsync_start;
	logic [timing_width-1:0] hsync_end;
	logic [timing_width-1:0] hscan;
	// vertical timing.
	logic [timing_width-1:0] vres;
	logic [timing_width-1:0] vsync_start;
	logic [timing_width-1:0] vsync_end;
	logic [timing_width-1:0] vscan;
	// dma setup.
	logic [fml_depth-1:0] baseaddress;
	logic [nbursts_width-1:0] nbursts;
	// base latched by fetch at frame start.
	logic baseaddress_ack;

	modport ctl (
		output vga_rst, hres, hsync_start, hsync_end, hscan,
		output vres, vsync_start, vsync_end, vscan,
		output baseaddress, nbursts,
		input baseaddress_ack
	);
	modport timing (
		input vga_rst, hres, hsync_start, hsync_end, hscan,
		input vres, vsync_start, vsync_end, vscan
	);
	modport fetch (
		input vga_rst, baseaddress, nbursts,
		output baseaddress_ack
	);
endinterface

`default_nettype wire

// ==== vgafb_pkg.sv ====
//////////////////////////////
// vga framebuffer constants
//////////////////////////////
`default_nettype none

package vgafb_pkg;
	// csr bus shape and bank number.
	localparam int csr_aw = 14;
	localparam int csr_dw = 32;
	localparam logic [3:0] csr_addr = 4'h0;

	// memory port, four beats of 64 bits per burst.
	localparam int fml_depth = 26;
	localparam int mem_dw = 64;
	localparam int burst_len = 4;
	localparam int burst_bytes = 32;
	localparam int beat_w = $clog2(burst_len);
	localparam logic [beat_w-1:0] last_beat = beat_w'(burst_len - 1);

	// pixels and fifo, depth must be a power of two.
	localparam int pix_w = 16;
	localparam int pix_per_word = mem_dw / pix_w;
	localparam int lane_w = $clog2(pix_per_word);
	localparam logic [lane_w-1:0] last_lane = lane_w'(pix_per_word - 1);
	localparam int fifo_depth_words = 16;
	localparam int fifo_aw = $clog2(fifo_depth_words);

	// register widths.
	localparam int timing_width = 11;
	localparam int nbursts_width = 18;
	localparam int clk_sel_width = 2;

	// register map.
	localparam logic [3:0] reg_vga_rst = 4'd0;
	localparam logic [3:0] reg_hres = 4'd1;
	localparam logic [3:0] reg_hsync_start = 4'd2;
	localparam logic [3:0] reg_hsync_end = 4'd3;
	localparam logic [3:0] reg_hscan = 4'd4;
	localparam logic [3:0] reg_vres = 4'd5;
	localparam logic [3:0] reg_vsync_start = 4'd6;
	localparam logic [3:0] reg_vsync_end = 4'd7;
	localparam logic [3:0] reg_vscan = 4'd8;
	localparam logic [3:0] reg_baseaddress = 4'd9;
	localparam logic [3:0] reg_baseaddress_act = 4'd10;
	localparam logic [3:0] reg_nbursts = 4'd11;
	localparam logic [3:0] reg_vga_clk_sel = 4'd12;

	// reset values, 640x480 at 60 hz.
	localparam logic rst_vga_rst = 1'b1;
	localparam logic [timing_width-1:0] rst_hres = 11'd640;
	localparam logic [timing_width-1:0] rst_hsync_start = 11'd656;
	localparam logic [timing_width-1:0] rst_hsync_end = 11'd752;
	localparam logic [timing_width-1:0] rst_hscan = 11'd799;
	localparam logic [timing_width-1:0] rst_vres = 11'd480;
	localparam logic [timing_width-1:0] rst_vsync_start = 11'd491;
	localparam logic [timing_width-1:0] rst_vsync_end = 11'd493;
	localparam logic [timing_width-1:0] rst_vscan = 11'd523;
	localparam logic [nbursts_width-1:0] rst_nbursts = 18'd19200;
	localparam logic [clk_sel_width-1:0] rst_clk_sel = 2'd0;

	// fetch fsm encoding.
	localparam logic [1:0] fetch_idle = 2'd0;
	localparam logic [1:0] fetch_req = 2'd1;
	localparam logic [1:0] fetch_beats = 2'd2;
endpackage

`default_nettype wire
